//--- src/frame_pkg.sv
package frame_pkg;

    // ==================================================
    // Sizes of the host line, the producer word and the frame ring
    // ==================================================

    localparam int LINE_WIDTH = 128;
    localparam int DATA_WIDTH = 64;

    // A frame is 2**LOG_FRAME_CHUNKS lines, line 0 being the header
    localparam int LOG_FRAME_CHUNKS = 3;
    localparam int LOG_FRAME_NUMBER = 2;
    localparam int LOG_FRAME_BASE   = 10;

    // Host addresses are counted in whole lines
    localparam int ADDR_WIDTH = LOG_FRAME_BASE + LOG_FRAME_NUMBER + LOG_FRAME_CHUNKS;

    // Data chunks run from index 1 up to the all-ones index
    localparam logic [LOG_FRAME_CHUNKS-1:0] FIRST_CHUNK = 1;
    localparam logic [LOG_FRAME_CHUNKS-1:0] LAST_CHUNK  = '1;

    // Pattern that software looks for to recognise a closed frame
    localparam logic [15:0] CTRL_MARKER = 16'hbeef;

    // Unused upper part of the control line
    localparam int CTRL_PAD_WIDTH = LINE_WIDTH - 16 - LOG_FRAME_CHUNKS - 1;

    // ==================================================
    // Host request and response formats
    // ==================================================

    typedef enum logic [1:0] {
        REQ_RD_LINE  = 2'd0,
        REQ_WR_LINE  = 2'd1,
        REQ_WR_FENCE = 2'd2
    } req_type_e;

    // Tag echoed back by the host with a read reply
    typedef struct packed {
        logic is_header;
        logic is_read;
    } req_tag_t;

    typedef struct packed {
        req_type_e               req_type;
        logic [ADDR_WIDTH-1:0]   address;
        req_tag_t                tag;
    } mem_hdr_t;

    // Layout of line 0 of a frame, with the valid bit in bit 0
    typedef struct packed {
        logic [CTRL_PAD_WIDTH-1:0]   pad;
        logic [15:0]                 marker;
        logic [LOG_FRAME_CHUNKS-1:0] chunk_count;
        logic                        in_use;
    } frame_ctrl_t;

    // One host line, seen either as raw chunk data or as a control word
    typedef union packed {
        logic [LINE_WIDTH-1:0] raw;
        frame_ctrl_t           ctrl;
    } cache_line_u;

    typedef struct packed {
        logic        read_request;
        logic        write_request;
        mem_hdr_t    read_hdr;
        mem_hdr_t    write_hdr;
        cache_line_u data;
    } host_req_t;

    typedef struct packed {
        logic        rd_valid;
        req_tag_t    tag;
        cache_line_u line;
    } host_rsp_t;

    // Writer FSM states, also decoded by the counter and the builder
    typedef enum logic [2:0] {
        IDLE          = 3'd0,
        POLL_HEADER   = 3'd1,
        WAIT_HEADER   = 3'd2,
        WRITE         = 3'd3,
        WRITE_FENCE   = 3'd4,
        WRITE_CONTROL = 3'd5
    } frame_state_e;

endpackage

//--- src/frame_tx_fifo.sv
`timescale 1ns/10ps

module frame_tx_fifo
    import frame_pkg::*;
#(
    parameter int DEPTH = 16
)
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [DATA_WIDTH-1:0] tx_data,
    input  logic                  tx_enable,
    input  logic                  chunk_write,
    output logic                  tx_rdy,
    output logic [DATA_WIDTH-1:0] fifo_data,
    output logic                  fifo_nonempty
);

    localparam int PTR_W = $clog2(DEPTH);

    logic [DATA_WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0]      wr_ptr;
    logic [PTR_W-1:0]      rd_ptr;
    logic [PTR_W:0]        count;
    logic [PTR_W:0]        count_next;
    logic                  push;

    // A word is taken only while the producer sees ready
    assign push = tx_enable && tx_rdy;

    // Occupancy after this cycle's push and pop
    always_comb
    begin
        count_next = count;
        if (push && !chunk_write)
            count_next = count + 1'b1;
        else if (!push && chunk_write)
            count_next = count - 1'b1;
    end

    // Pointers and count; ready stays low in reset and rises one cycle later
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            tx_rdy <= 1'b0;
        end
        else
        begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (chunk_write)
                rd_ptr <= rd_ptr + 1'b1;
            count  <= count_next;
            tx_rdy <= (count_next != DEPTH[PTR_W:0]);
        end
    end

    // Storage holds payload only
    always_ff @(posedge clk)
    begin
        if (push)
            mem[wr_ptr] <= tx_data;
    end

    // The head word is shown before it is popped
    assign fifo_data     = mem[rd_ptr];
    assign fifo_nonempty = (count != '0);

    // The FSM only dequeues when it has seen a word waiting
    a_no_pop_when_empty: assert property (@(posedge clk) disable iff (!rst_n)
        chunk_write |-> fifo_nonempty);

endmodule

//--- src/frame_position_counter.sv
`timescale 1ns/10ps

module frame_position_counter
    import frame_pkg::*;
#(
    parameter int IDLE_LIMIT = 15
)
(
    input  logic                        clk,
    input  logic                        rst_n,
    input  frame_state_e                state,
    input  logic                        read_grant,
    input  logic                        chunk_write,
    input  logic                        control_done,
    input  logic                        fifo_nonempty,
    output logic [LOG_FRAME_NUMBER-1:0] frame_number,
    output logic [LOG_FRAME_CHUNKS-1:0] chunk_index,
    output logic                        frame_done
);

    localparam logic [7:0] IDLE_MAX = 8'(IDLE_LIMIT);

    logic [7:0] idle_count;

    // ==================================================
    // Ring position and chunk index
    // ==================================================

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            frame_number <= '0;
            chunk_index  <= FIRST_CHUNK;
        end
        else
        begin
            // The ring restarts from frame 0 each time the writer leaves IDLE
            if (state == IDLE)
                frame_number <= '0;
            else if (control_done)
                frame_number <= frame_number + 1'b1;

            // Data always starts one line past the header
            if (state == POLL_HEADER && read_grant)
                chunk_index <= FIRST_CHUNK;
            else if (chunk_write)
                chunk_index <= chunk_index + 1'b1;
        end
    end

    // Idle timer, held at zero while words wait and saturating otherwise
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            idle_count <= '0;
        else if (fifo_nonempty)
            idle_count <= '0;
        else if (idle_count != IDLE_MAX)
            idle_count <= idle_count + 1'b1;
    end

    // Close a frame once data went quiet after at least one chunk,
    // or as the last chunk line is accepted so the index can not run into the header
    assign frame_done = (idle_count == IDLE_MAX && !fifo_nonempty &&
                         chunk_index != FIRST_CHUNK) ||
                        (chunk_index == LAST_CHUNK && chunk_write);

    // A wrapped index would aim a data write at the header line
    a_no_wrap_in_write: assert property (@(posedge clk) disable iff (!rst_n)
        (state == WRITE) |-> (chunk_index != '0));

endmodule

//--- src/frame_writer_fsm.sv
`timescale 1ns/10ps

module frame_writer_fsm
    import frame_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  logic         enable,
    input  logic         read_grant,
    input  logic         write_grant,
    input  host_rsp_t    rsp,
    input  logic         fifo_nonempty,
    input  logic         frame_done,
    output frame_state_e state,
    output logic         chunk_write,
    output logic         control_done
);

    frame_state_e next_state;
    frame_ctrl_t  rsp_ctrl;
    logic         header_valid;

    // The header reply is decoded through the control view of the line
    assign rsp_ctrl = rsp.line.ctrl;

    // Only a header read reply ends the wait
    assign header_valid = rsp.rd_valid && rsp.tag.is_header && !rsp.tag.is_read;

    // A granted write in WRITE consumes the head word of the FIFO
    assign chunk_write = (state == WRITE) && write_grant && fifo_nonempty;

    // The control line is accepted and the frame is handed to software
    assign control_done = (state == WRITE_CONTROL) && write_grant;

    // ==================================================
    // State register
    // ==================================================

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            state <= IDLE;
        else if (!enable)
            state <= IDLE;
        else
            state <= next_state;
    end

    // ==================================================
    // Next state
    // ==================================================

    always_comb
    begin
        next_state = state;
        case (state)
            IDLE:
                next_state = POLL_HEADER;
            POLL_HEADER:
                // One read is outstanding at a time
                if (read_grant)
                    next_state = WAIT_HEADER;
            WAIT_HEADER:
                // Software still owns the frame so the header is read again
                if (header_valid)
                    next_state = rsp_ctrl.in_use ? POLL_HEADER : WRITE;
            WRITE:
                if (frame_done)
                    next_state = WRITE_FENCE;
            WRITE_FENCE:
                // Data lines must be ordered ahead of the control line
                if (write_grant)
                    next_state = WRITE_CONTROL;
            WRITE_CONTROL:
                if (write_grant)
                    next_state = POLL_HEADER;
            default:
                next_state = IDLE;
        endcase
    end

    a_legal_state: assert property (@(posedge clk) disable iff (!rst_n)
        state inside {IDLE, POLL_HEADER, WAIT_HEADER, WRITE, WRITE_FENCE, WRITE_CONTROL});

endmodule

//--- src/frame_request_builder.sv
`timescale 1ns/10ps

module frame_request_builder
    import frame_pkg::*;
(
    input  frame_state_e                state,
    input  logic [LOG_FRAME_BASE-1:0]   frame_base,
    input  logic [LOG_FRAME_NUMBER-1:0] frame_number,
    input  logic [LOG_FRAME_CHUNKS-1:0] chunk_index,
    input  logic [DATA_WIDTH-1:0]       fifo_data,
    input  logic                        fifo_nonempty,
    output host_req_t                   host_req
);

    frame_ctrl_t ctrl_word;

    // Control word for the frame being closed, count excludes the header line
    always_comb
    begin
        ctrl_word             = '0;
        ctrl_word.marker      = CTRL_MARKER;
        ctrl_word.chunk_count = chunk_index - 1'b1;
        ctrl_word.in_use      = 1'b1;
    end

    always_comb
    begin
        host_req = '0;

        // Request levels, held by the state until the matching grant
        host_req.read_request  = (state == POLL_HEADER);
        host_req.write_request = (state == WRITE_FENCE) || (state == WRITE_CONTROL) ||
                                 (state == WRITE && fifo_nonempty);

        // Header poll reads line 0 of the current frame
        host_req.read_hdr.req_type      = REQ_RD_LINE;
        host_req.read_hdr.address       = {frame_base, frame_number, {LOG_FRAME_CHUNKS{1'b0}}};
        host_req.read_hdr.tag.is_header = 1'b1;
        host_req.read_hdr.tag.is_read   = 1'b0;

        host_req.write_hdr.req_type = (state == WRITE_FENCE) ? REQ_WR_FENCE : REQ_WR_LINE;
        case (state)
            WRITE_FENCE:
                host_req.write_hdr.address = '0;
            WRITE_CONTROL:
                host_req.write_hdr.address = {frame_base, frame_number,
                                              {LOG_FRAME_CHUNKS{1'b0}}};
            default:
                host_req.write_hdr.address = {frame_base, frame_number, chunk_index};
        endcase

        // Chunk data is zero-extended, anything else carries the control word
        if (state == WRITE)
            host_req.data.raw = {{(LINE_WIDTH-DATA_WIDTH){1'b0}}, fifo_data};
        else
            host_req.data.ctrl = ctrl_word;
    end

endmodule

//--- src/host_frame_writer.sv
`timescale 1ns/10ps

module host_frame_writer
    import frame_pkg::*;
#(
    parameter int FIFO_DEPTH = 16,
    parameter int IDLE_LIMIT = 15
)
(
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      enable,
    input  logic [LOG_FRAME_BASE-1:0] frame_base,
    input  logic [DATA_WIDTH-1:0]     tx_data,
    input  logic                      tx_enable,
    output logic                      tx_rdy,
    output host_req_t                 host_req,
    input  host_rsp_t                 rsp,
    input  logic                      read_grant,
    input  logic                      write_grant
);

    logic [DATA_WIDTH-1:0]       fifo_data;
    logic                        fifo_nonempty;
    logic                        chunk_write;
    logic                        control_done;
    logic                        frame_done;
    logic [LOG_FRAME_NUMBER-1:0] frame_number;
    logic [LOG_FRAME_CHUNKS-1:0] chunk_index;
    frame_state_e                state;

    // Producer words wait here until the frame is open
    frame_tx_fifo #(
        .DEPTH(FIFO_DEPTH)
    ) u_fifo (
        .clk           (clk),
        .rst_n         (rst_n),
        .tx_data       (tx_data),
        .tx_enable     (tx_enable),
        .chunk_write   (chunk_write),
        .tx_rdy        (tx_rdy),
        .fifo_data     (fifo_data),
        .fifo_nonempty (fifo_nonempty)
    );

    frame_position_counter #(
        .IDLE_LIMIT(IDLE_LIMIT)
    ) u_counter (
        .clk           (clk),
        .rst_n         (rst_n),
        .state         (state),
        .read_grant    (read_grant),
        .chunk_write   (chunk_write),
        .control_done  (control_done),
        .fifo_nonempty (fifo_nonempty),
        .frame_number  (frame_number),
        .chunk_index   (chunk_index),
        .frame_done    (frame_done)
    );

    frame_writer_fsm u_fsm (
        .clk           (clk),
        .rst_n         (rst_n),
        .enable        (enable),
        .read_grant    (read_grant),
        .write_grant   (write_grant),
        .rsp           (rsp),
        .fifo_nonempty (fifo_nonempty),
        .frame_done    (frame_done),
        .state         (state),
        .chunk_write   (chunk_write),
        .control_done  (control_done)
    );

    // Request levels, headers and line data for the host channel
    frame_request_builder u_builder (
        .state         (state),
        .frame_base    (frame_base),
        .frame_number  (frame_number),
        .chunk_index   (chunk_index),
        .fifo_data     (fifo_data),
        .fifo_nonempty (fifo_nonempty),
        .host_req      (host_req)
    );

endmodule

//--- tests/host_memory_model.sv
`timescale 1ns/10ps

module host_memory_model
    import frame_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  host_req_t host_req,
    output host_rsp_t rsp,
    output logic      read_grant,
    output logic      write_grant
);

    // Header polls still to be answered as in use, set by the testbench
    int   busy_left;
    // Withholds every write grant while high
    logic hold_writes;

    int rd_delay;
    int wr_delay;
    int reply_wait;

    // Every accepted write, in acceptance order
    req_type_e             log_kind [$];
    logic [ADDR_WIDTH-1:0] log_addr [$];
    logic [LINE_WIDTH-1:0] log_data [$];

    // Every granted header read, in grant order
    mem_hdr_t              log_rd_hdr [$];

    initial
    begin
        busy_left   = 0;
        hold_writes = 1'b0;
        read_grant  = 1'b0;
        write_grant = 1'b0;
        rsp         = '0;
    end

    // Grants and replies change on the falling edge, the DUT samples them on the rising edge
    always @(negedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            read_grant  = 1'b0;
            write_grant = 1'b0;
            rsp         = '0;
            rd_delay    = 0;
            wr_delay    = 0;
            reply_wait  = 0;
        end
        else
        begin
            read_grant   = 1'b0;
            write_grant  = 1'b0;
            rsp.rd_valid = 1'b0;
            // A pending header reply goes out 1 to 4 cycles after its grant
            if (reply_wait > 0)
            begin
                reply_wait = reply_wait - 1;
                if (reply_wait == 0)
                begin
                    rsp.rd_valid          = 1'b1;
                    rsp.tag.is_header     = 1'b1;
                    rsp.tag.is_read       = 1'b0;
                    rsp.line              = '0;
                    rsp.line.ctrl.in_use  = (busy_left > 0);
                    if (busy_left > 0)
                        busy_left = busy_left - 1;
                end
            end
            else if (host_req.read_request)
            begin
                if (rd_delay == 0)
                begin
                    read_grant = 1'b1;
                    log_rd_hdr.push_back(host_req.read_hdr);
                    reply_wait = 1 + $urandom_range(0, 3);
                    rd_delay   = $urandom_range(0, 3);
                end
                else
                    rd_delay = rd_delay - 1;
            end
            if (host_req.write_request && !hold_writes)
            begin
                if (wr_delay == 0)
                begin
                    // The request is held stable, so the grant accepts what is seen now
                    write_grant = 1'b1;
                    log_kind.push_back(host_req.write_hdr.req_type);
                    log_addr.push_back(host_req.write_hdr.address);
                    log_data.push_back(host_req.data.raw);
                    wr_delay = $urandom_range(0, 3);
                end
                else
                    wr_delay = wr_delay - 1;
            end
        end
    end

endmodule

//--- tests/tb_host_frame_writer.sv
`timescale 1ns/10ps

module tb_host_frame_writer
    import frame_pkg::*;
;

    localparam int FIFO_DEPTH = 16;
    localparam int IDLE_LIMIT = 15;
    localparam logic [LOG_FRAME_BASE-1:0] FRAME_BASE = 10'h2a5;

    logic                  clk;
    logic                  rst_n;
    logic                  enable;
    logic [DATA_WIDTH-1:0] tx_data;
    logic                  tx_enable;
    logic                  tx_rdy;
    host_req_t             host_req;
    host_rsp_t             rsp;
    logic                  read_grant;
    logic                  write_grant;

    // Expected host writes, filled ahead of the stimulus
    req_type_e             exp_kind [$];
    logic [ADDR_WIDTH-1:0] exp_addr [$];
    logic [LINE_WIDTH-1:0] exp_data [$];

    int ref_frame;
    int ref_chunk;
    int checked;
    int mismatches;
    int failures;

    // Frame whose header the next poll must read
    int poll_frame;
    int rd_checked;

    host_frame_writer #(
        .FIFO_DEPTH(FIFO_DEPTH),
        .IDLE_LIMIT(IDLE_LIMIT)
    ) UUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .enable      (enable),
        .frame_base  (FRAME_BASE),
        .tx_data     (tx_data),
        .tx_enable   (tx_enable),
        .tx_rdy      (tx_rdy),
        .host_req    (host_req),
        .rsp         (rsp),
        .read_grant  (read_grant),
        .write_grant (write_grant)
    );

    host_memory_model mem_model (
        .clk         (clk),
        .rst_n       (rst_n),
        .host_req    (host_req),
        .rsp         (rsp),
        .read_grant  (read_grant),
        .write_grant (write_grant)
    );

    always #20 clk = ~clk;

    // ==================================================
    // Reference model of the frame layout
    // ==================================================

    function automatic logic [ADDR_WIDTH-1:0] chunk_addr(input int frame, input int chunk);
        return {FRAME_BASE, frame[1:0], chunk[2:0]};
    endfunction

    // Bit 0 valid, then the count, then the marker, zero above
    function automatic logic [LINE_WIDTH-1:0] control_line(input int count);
        return {108'd0, CTRL_MARKER, count[2:0], 1'b1};
    endfunction

    function automatic int frame_of(input logic [ADDR_WIDTH-1:0] addr);
        return int'(addr[4:3]);
    endfunction

    // Header poll of a frame reads line 0 and is tagged as a header read
    function automatic mem_hdr_t poll_hdr(input int frame);
        mem_hdr_t h;
        h.req_type      = REQ_RD_LINE;
        h.address       = chunk_addr(frame, 0);
        h.tag.is_header = 1'b1;
        h.tag.is_read   = 1'b0;
        return h;
    endfunction

    // Fence first, then the control line at chunk 0, then the next frame of the ring
    task automatic expect_close();
        exp_kind.push_back(REQ_WR_FENCE);
        exp_addr.push_back('0);
        exp_data.push_back('0);
        exp_kind.push_back(REQ_WR_LINE);
        exp_addr.push_back(chunk_addr(ref_frame, 0));
        exp_data.push_back(control_line(ref_chunk - 1));
        ref_frame = (ref_frame + 1) % 4;
        ref_chunk = 1;
    endtask

    // A full frame closes on its own after chunk 7
    task automatic expect_word(input logic [DATA_WIDTH-1:0] w);
        exp_kind.push_back(REQ_WR_LINE);
        exp_addr.push_back(chunk_addr(ref_frame, ref_chunk));
        exp_data.push_back({64'd0, w});
        ref_chunk = ref_chunk + 1;
        if (ref_chunk == 8)
            expect_close();
    endtask

    // ==================================================
    // Comparison of logged writes
    // ==================================================

    always @(posedge clk)
    begin
        while (checked < mem_model.log_kind.size())
        begin
            if (checked >= exp_kind.size())
            begin
                failures++;
                $display("ERROR: host write %0d to frame %0d was not expected", checked,
                         frame_of(mem_model.log_addr[checked]));
            end
            else
            begin
                assert (mem_model.log_kind[checked] == exp_kind[checked] &&
                        mem_model.log_addr[checked] == exp_addr[checked])
                else
                begin
                    mismatches++;
                    $display("MISMATCH at %0t: write %0d kind %0d addr %h, expected %0d %h",
                             $time, checked, mem_model.log_kind[checked],
                             mem_model.log_addr[checked], exp_kind[checked],
                             exp_addr[checked]);
                end
                // Fence data carries no meaning
                if (exp_kind[checked] != REQ_WR_FENCE)
                    assert (mem_model.log_data[checked] == exp_data[checked])
                    else
                    begin
                        mismatches++;
                        $display("MISMATCH at %0t: write %0d frame %0d data %h, expected %h",
                                 $time, checked, frame_of(exp_addr[checked]),
                                 mem_model.log_data[checked], exp_data[checked]);
                    end
                // A control line hands the next poll to the following frame of the ring
                if (exp_kind[checked] == REQ_WR_LINE && exp_addr[checked][2:0] == 3'd0)
                    poll_frame = (frame_of(exp_addr[checked]) + 1) % 4;
            end
            checked++;
        end
        while (rd_checked < mem_model.log_rd_hdr.size())
        begin
            assert (mem_model.log_rd_hdr[rd_checked] == poll_hdr(poll_frame))
            else
            begin
                mismatches++;
                $display("MISMATCH at %0t: header poll %0d sent %h, expected %h",
                         $time, rd_checked, mem_model.log_rd_hdr[rd_checked],
                         poll_hdr(poll_frame));
            end
            rd_checked++;
        end
    end

    // ==================================================
    // Stimulus helpers, all called on a falling edge
    // ==================================================

    task automatic push_word(input logic [DATA_WIDTH-1:0] w);
        int t;
        t = 0;
        while (!tx_rdy && t < 500)
        begin
            tx_enable = 1'b0;
            t++;
            @(negedge clk);
        end
        if (!tx_rdy)
        begin
            failures++;
            $display("ERROR: tx_rdy stayed low, the producer could not push a word");
        end
        else
        begin
            tx_data   = w;
            tx_enable = 1'b1;
            expect_word(w);
            @(negedge clk);
        end
        tx_enable = 1'b0;
    endtask

    task automatic push_burst(input int n);
        for (int i = 0; i < n; i++)
            push_word({$urandom, $urandom});
    endtask

    // Waits until every expected write has been seen
    task automatic wait_drained();
        int t;
        t = 0;
        while (checked < exp_kind.size() && t < 3000)
        begin
            t++;
            @(negedge clk);
        end
        if (checked < exp_kind.size())
        begin
            failures++;
            $display("ERROR: timed out with %0d of %0d expected writes seen",
                     checked, exp_kind.size());
        end
    endtask

    int accepted;
    int rejected;
    int t;
    int log_mark;

    initial
    begin
        void'($urandom(58669));
        clk        = 1'b0;
        rst_n      = 1'b0;
        enable     = 1'b0;
        tx_data    = '0;
        tx_enable  = 1'b0;
        ref_frame  = 0;
        ref_chunk  = 1;
        checked    = 0;
        mismatches = 0;
        failures   = 0;
        poll_frame = 0;
        rd_checked = 0;
        repeat (16) @(negedge clk);
        rst_n  = 1'b1;
        enable = 1'b1;
        @(negedge clk);

        // Short burst into frame 0, closed by the idle timer
        push_burst(4);
        expect_close();
        wait_drained();

        // Frames 1 to 3 fill up, the last one closes idle and the ring wraps
        push_burst(20);
        expect_close();
        wait_drained();

        // The header of frame 0 is polled busy three times while words wait
        mem_model.busy_left = 3;
        log_mark = mem_model.log_kind.size();
        push_burst(3);
        t = 0;
        while (mem_model.busy_left != 0 && t < 500)
        begin
            t++;
            @(negedge clk);
        end
        if (mem_model.busy_left != 0)
        begin
            failures++;
            $display("ERROR: timed out waiting for the busy header polls");
        end
        assert (mem_model.log_kind.size() == log_mark)
        else
        begin
            failures++;
            $display("ERROR: host writes happened while the frame header was in use");
        end
        expect_close();
        wait_drained();

        // Once freed the ring moves on to frame 1 as usual
        push_burst(2);
        expect_close();
        wait_drained();

        // Write grants held, the FIFO fills and refuses further words
        mem_model.hold_writes = 1'b1;
        accepted = 0;
        rejected = 0;
        t = 0;
        while (rejected < 8 && t < 200)
        begin
            tx_data   = {$urandom, $urandom};
            tx_enable = 1'b1;
            if (tx_rdy)
            begin
                accepted++;
                expect_word(tx_data);
            end
            else
                rejected++;
            t++;
            @(negedge clk);
        end
        tx_enable = 1'b0;
        assert (accepted == FIFO_DEPTH && !tx_rdy)
        else
        begin
            mismatches++;
            $display("MISMATCH at %0t: tx_rdy fell after %0d words, expected %0d",
                     $time, accepted, FIFO_DEPTH);
        end
        mem_model.hold_writes = 1'b0;
        expect_close();
        wait_drained();

        // Dropping enable restarts the ring at frame 0 from frame 1
        repeat (20) @(negedge clk);
        enable     = 1'b0;
        poll_frame = 0;
        repeat (4) @(negedge clk);
        enable    = 1'b1;
        ref_frame = 0;
        ref_chunk = 1;
        push_burst(3);
        expect_close();
        wait_drained();
        repeat (40) @(negedge clk);

        $display("Checked %0d writes, %0d mismatches, %0d other errors",
                 checked, mismatches, failures);
        if (mismatches == 0 && failures == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

//--- project.f
src/frame_pkg.sv
src/frame_tx_fifo.sv
src/frame_position_counter.sv
src/frame_writer_fsm.sv
src/frame_request_builder.sv
src/host_frame_writer.sv
tests/host_memory_model.sv
tests/tb_host_frame_writer.sv

//--- Makefile
# Verilator build and run of the frame writer testbench
VERILATOR ?= verilator
TOP       ?= tb_host_frame_writer
FLIST     ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; true
	cat $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	elif ! grep -q "TEST RESULT: PASS" $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
